/* verilog.f */
design/chip_io_pkg.sv
design/pad_bank.sv
design/jtag_overlay_mux.sv
design/chip_io_top.sv
tb/chip_io_assertions.sv
tb/chip_io_tb.sv

/* Makefile */
TOP := chip_io_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f verilog.f --top-module $(TOP) --Mdir obj_dir -o V$(TOP)
	-./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL: run ended without a result"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* tb/chip_io_tb.sv */
// MIO 6-7 are open drain, DIO 0-1 input only and the strap enables JTAG at 1
// The bound assertions do the checking and each test reports the failures it caused
`default_nettype none

module chip_io_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumMio = chip_io_pkg::NumMioDefault;
  localparam int NumDio = chip_io_pkg::NumDioDefault;
  localparam int StrapIdx = chip_io_pkg::JtagEnIdxDefault;
  localparam int ResetCycles = 3;
  localparam int DrainCycles = 2;   // Checks still due after the last stimulus
  localparam int TestCycles = 24;   // Length of each stimulus test
  localparam int NumStimTests = 4;
  localparam int WatchdogNs =
      ((ResetCycles + DrainCycles) + NumStimTests * (TestCycles + DrainCycles) + 20) * 4;

  localparam chip_io_pkg::pad_variant_e [NumMio-1:0] MioVar = '{
    chip_io_pkg::open_drain, chip_io_pkg::open_drain,  // MIO 7, 6
    chip_io_pkg::bidir, chip_io_pkg::bidir, chip_io_pkg::bidir,
    chip_io_pkg::bidir, chip_io_pkg::bidir, chip_io_pkg::bidir
  };
  localparam chip_io_pkg::pad_variant_e [NumDio-1:0] DioVar = '{
    chip_io_pkg::bidir, chip_io_pkg::tolerant, chip_io_pkg::bidir,
    chip_io_pkg::bidir,
    chip_io_pkg::input_only, chip_io_pkg::input_only  // DIO 1, 0
  };

  // Stimulus modes
  localparam int ModeBidir   = 0;  // Invert only, strap off
  localparam int ModeOd      = 1;  // Invert and od_en, strap off
  localparam int ModeJtagOn  = 2;  // Strap on, no attributes
  localparam int ModeJtagOff = 3;  // Strap off, no attributes

  logic clk = 1'b0;
  logic rst_n;
  chip_io_pkg::pad_drive_t [NumMio-1:0] mio_drive;
  chip_io_pkg::pad_drive_t [NumDio-1:0] dio_drive;
  chip_io_pkg::pad_attr_t  [NumMio-1:0] mio_attr;
  chip_io_pkg::pad_attr_t  [NumDio-1:0] dio_attr;
  logic [NumMio-1:0] mio_in, mio_pad_in, mio_pad_out, mio_pad_oe;
  logic [NumDio-1:0] dio_in, dio_pad_in, dio_pad_out, dio_pad_oe;
  chip_io_pkg::jtag_t jtag;
  logic tdo;

  int seed = 11;
  int tests_passed = 0;
  int tests_failed = 0;

  chip_io_top #(
    .NumMio         ( NumMio ),
    .NumDio         ( NumDio ),
    .MioVariant     ( MioVar ),
    .DioVariant     ( DioVar ),
    .JtagEnPolarity ( 1'b1   )
  ) dut0 (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .mio_drive_i   ( mio_drive   ),
    .mio_attr_i    ( mio_attr    ),
    .mio_in_o      ( mio_in      ),
    .dio_drive_i   ( dio_drive   ),
    .dio_attr_i    ( dio_attr    ),
    .dio_in_o      ( dio_in      ),
    .mio_pad_in_i  ( mio_pad_in  ),
    .mio_pad_out_o ( mio_pad_out ),
    .mio_pad_oe_o  ( mio_pad_oe  ),
    .dio_pad_in_i  ( dio_pad_in  ),
    .dio_pad_out_o ( dio_pad_out ),
    .dio_pad_oe_o  ( dio_pad_oe  ),
    .jtag_o        ( jtag        ),
    .jtag_tdo_i    ( tdo         )
  );

  initial begin
    forever #2 clk = ~clk;  // 4 ns period
  end

  // Reset low for the first ResetCycles rising edges
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // New random inputs for one cycle as the mode allows
  task automatic apply_stimulus(input int mode);
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    rnd_a = $random(seed);
    rnd_b = $random(seed);
    mio_drive  = rnd_a[2*NumMio-1:0];
    dio_drive  = rnd_a[31:32-2*NumDio];
    mio_pad_in = rnd_b[NumMio-1:0];
    dio_pad_in = rnd_b[NumMio+NumDio-1:NumMio];
    tdo        = rnd_b[31];
    rnd_a = $random(seed);
    mio_attr = '0;
    dio_attr = '0;
    for (int i = 0; i < NumMio; i++) begin
      mio_attr[i].invert = (mode == ModeBidir || mode == ModeOd) ? rnd_a[i] : 1'b0;
      mio_attr[i].od_en  = (mode == ModeOd) ? rnd_a[16+i] : 1'b0;
    end
    for (int i = 0; i < NumDio; i++) begin
      dio_attr[i].invert = (mode == ModeBidir || mode == ModeOd) ? rnd_a[8+i] : 1'b0;
      dio_attr[i].od_en  = (mode == ModeOd) ? rnd_a[24+i] : 1'b0;
    end
    mio_attr[StrapIdx]   = '0;                   // Strap read as is
    mio_pad_in[StrapIdx] = (mode == ModeJtagOn);
  endtask

  // Runs one test and reports the assertion failures it caused
  task automatic run_test(input string name, input int cycles, input int mode);
    int fails_before;
    int fails_new;
    fails_before = dut0.u_asserts.fail_cnt;
    repeat (cycles) begin
      @(negedge clk);
      apply_stimulus(mode);
    end
    repeat (DrainCycles) @(negedge clk);  // Let the last checks fire
    fails_new = dut0.u_asserts.fail_cnt - fails_before;
    if (fails_new == 0) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d assertion failures", name, fails_new);
    end
  endtask

  initial begin
    mio_drive  = '0;
    dio_drive  = '0;
    mio_attr   = '0;
    dio_attr   = '0;
    mio_pad_in = '0;
    dio_pad_in = '0;
    tdo        = 1'b0;

    // Drives change while reset is held, then the first drive reaches the pads
    run_test("reset_idle", ResetCycles, ModeBidir);

    run_test("bidir_drive", TestCycles, ModeBidir);
    run_test("open_drain", TestCycles, ModeOd);
    run_test("jtag_on", TestCycles, ModeJtagOn);
    run_test("jtag_off", TestCycles, ModeJtagOff);

    $display("tests passed %0d, failed %0d, assertion failures %0d",
             tests_passed, tests_failed, dut0.u_asserts.fail_cnt);
    if (tests_failed == 0 && dut0.u_asserts.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the test lengths plus a margin
  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule : chip_io_tb

`default_nettype wire

/* tb/chip_io_assertions.sv */
// Bound checker for chip_io_top; pad rules, input timing and the JTAG overlay
// Keeps its own short history of pad inputs and drives, fail_cnt counts failed checks
`default_nettype none

module chip_io_assertions #(
  parameter int   NumMio         = chip_io_pkg::NumMioDefault,
  parameter int   NumDio         = chip_io_pkg::NumDioDefault,
  parameter chip_io_pkg::pad_variant_e [NumMio-1:0] MioVariant =
      '{default: chip_io_pkg::bidir},
  parameter chip_io_pkg::pad_variant_e [NumDio-1:0] DioVariant =
      '{default: chip_io_pkg::bidir},
  parameter logic JtagEnPolarity = 1'b1
) (
  input wire logic                                 clk_i,
  input wire logic                                 rst_n_i,
  input wire chip_io_pkg::pad_drive_t [NumMio-1:0] mio_drive_i,
  input wire chip_io_pkg::pad_drive_t [NumDio-1:0] dio_drive_i,
  input wire chip_io_pkg::pad_attr_t  [NumMio-1:0] mio_attr_i,
  input wire chip_io_pkg::pad_attr_t  [NumDio-1:0] dio_attr_i,
  input wire logic                    [NumMio-1:0] mio_in_o,
  input wire logic                    [NumDio-1:0] dio_in_o,
  input wire logic                    [NumMio-1:0] mio_pad_in_i,
  input wire logic                    [NumDio-1:0] dio_pad_in_i,
  input wire logic                    [NumMio-1:0] mio_pad_out_o,
  input wire logic                    [NumMio-1:0] mio_pad_oe_o,
  input wire logic                    [NumDio-1:0] dio_pad_out_o,
  input wire logic                    [NumDio-1:0] dio_pad_oe_o,
  input wire chip_io_pkg::jtag_t                   jtag_o,
  input wire logic                                 jtag_tdo_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumIOs  = NumMio + NumDio;              // DIO above MIO
  localparam int StrapIdx = chip_io_pkg::JtagEnIdxDefault;
  localparam int TckIdx  = NumMio + chip_io_pkg::DioSck;
  localparam int TmsIdx  = NumMio + chip_io_pkg::DioCsb;
  localparam int TdiIdx  = NumMio + chip_io_pkg::DioS0;
  localparam int TdoIdx  = NumMio + chip_io_pkg::DioS1;
  localparam int TrstIdx = chip_io_pkg::TrstIdxDefault;
  localparam int SrstIdx = chip_io_pkg::SrstIdxDefault;

  localparam logic [2*NumIOs-1:0] VarBits = {DioVariant, MioVariant};
  localparam logic [NumIOs-1:0] InMask = (NumIOs'(1) << TckIdx) | (NumIOs'(1) << TmsIdx) |
                                         (NumIOs'(1) << TrstIdx) | (NumIOs'(1) << SrstIdx) |
                                         (NumIOs'(1) << TdiIdx);
  localparam logic [NumIOs-1:0] TieOff = NumIOs'(1) << TmsIdx;  // CSB reads high
  localparam chip_io_pkg::jtag_t JtagOff = '{tck: 1'b0, tms: 1'b0, trst_n: 1'b0,
                                             srst_n: 1'b1, tdi: 1'b0};

  int fail_cnt = 0;  // Read by the testbench

  ////////////////////////////////////////////////////////////////////////////
  // Joined views and history
  ////////////////////////////////////////////////////////////////////////////

  chip_io_pkg::pad_drive_t [NumIOs-1:0] drive;
  chip_io_pkg::pad_attr_t  [NumIOs-1:0] attr;
  chip_io_pkg::pad_drive_t [NumIOs-1:0] drive_q;  // One cycle back
  chip_io_pkg::pad_attr_t  [NumIOs-1:0] attr_q;
  logic [NumIOs-1:0] pad_in, pad_out, pad_oe, core_in, inv;
  logic [NumIOs-1:0] pad_in_q1, pad_in_q2;  // Pad inputs one and two cycles back
  logic [NumIOs-1:0] pad_seen;              // Expected synced and inverted value
  logic              jtag_on, jtag_on_q, tdo_q;
  logic [1:0]        run_cnt;               // Cycles since reset, saturates
  chip_io_pkg::jtag_t exp_jtag;

  assign drive   = {dio_drive_i, mio_drive_i};
  assign attr    = {dio_attr_i, mio_attr_i};
  assign pad_in  = {dio_pad_in_i, mio_pad_in_i};
  assign pad_out = {dio_pad_out_o, mio_pad_out_o};
  assign pad_oe  = {dio_pad_oe_o, mio_pad_oe_o};
  assign core_in = {dio_in_o, mio_in_o};

  always_comb begin
    for (int i = 0; i < NumIOs; i++) begin
      inv[i] = attr[i].invert;
    end
  end

  assign pad_seen = pad_in_q2 ^ inv;
  assign jtag_on  = (pad_seen[StrapIdx] == JtagEnPolarity);  // Strap after sync

  assign exp_jtag = '{tck: pad_seen[TckIdx], tms: pad_seen[TmsIdx],
                      trst_n: pad_seen[TrstIdx], srst_n: pad_seen[SrstIdx],
                      tdi: pad_seen[TdiIdx]};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_cnt   <= '0;
      pad_in_q1 <= '0;
      pad_in_q2 <= '0;
    end else begin
      if (run_cnt != 2'd3) run_cnt <= run_cnt + 2'd1;
      pad_in_q1 <= pad_in;
      pad_in_q2 <= pad_in_q1;
    end
    drive_q   <= drive;
    attr_q    <= attr;
    jtag_on_q <= jtag_on;
    tdo_q     <= jtag_tdo_i;
  end

  // Pad drive from one cycle of core drive and attributes, per variant
  function automatic logic [1:0] exp_drive(input logic [1:0] v,
                                           input chip_io_pkg::pad_drive_t d,
                                           input chip_io_pkg::pad_attr_t a);
    logic val;
    val = d.out ^ a.invert;
    if (v == chip_io_pkg::input_only) return 2'b00;
    if (v == chip_io_pkg::open_drain || a.od_en) return {1'b0, d.oe & ~val};
    return {val, d.oe};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Per-pad checks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumIOs; i++) begin : g_pad
    a_drive: assert property (@(posedge clk_i)
        (run_cnt != 0 && !(jtag_on_q && (InMask[i] || i == TdoIdx))) |->
        ({pad_out[i], pad_oe[i]} == exp_drive(VarBits[2*i +: 2], drive_q[i], attr_q[i])))
      else begin
        fail_cnt++;
        $error("Mismatch pad_drive[%0d]: expected %b actual %b", i,
               exp_drive(VarBits[2*i +: 2], drive_q[i], attr_q[i]), {pad_out[i], pad_oe[i]});
      end

    a_od: assert property (@(posedge clk_i)
        (run_cnt != 0 && pad_oe[i] &&
         (VarBits[2*i +: 2] == chip_io_pkg::open_drain || attr_q[i].od_en)) |-> !pad_out[i])
      else begin
        fail_cnt++;
        $error("Open-drain pad %0d drives a high level", i);
      end

    if (VarBits[2*i +: 2] == chip_io_pkg::input_only) begin : g_in_only
      a_no_oe: assert property (@(posedge clk_i) !pad_oe[i])
        else begin
          fail_cnt++;
          $error("Input-only pad %0d has its output enabled", i);
        end
    end

    a_core_in: assert property (@(posedge clk_i)
        (run_cnt >= 2 && !(jtag_on && InMask[i])) |-> core_in[i] == pad_seen[i])
      else begin
        fail_cnt++;
        $error("Mismatch core_in[%0d]: expected %b actual %b", i, pad_seen[i], core_in[i]);
      end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reset and JTAG checks
  ////////////////////////////////////////////////////////////////////////////

  a_reset_oe: assert property (@(posedge clk_i) $past(!rst_n_i) |-> pad_oe == '0)
    else begin
      fail_cnt++;
      $error("Pad output enabled right after reset: %b", pad_oe);
    end

  a_jtag_in: assert property (@(posedge clk_i) (run_cnt >= 2 && jtag_on) |-> jtag_o == exp_jtag)
    else begin
      fail_cnt++;
      $error("Mismatch jtag_o: expected %b actual %b", exp_jtag, jtag_o);
    end

  a_tie_off: assert property (@(posedge clk_i)
      (run_cnt >= 2 && jtag_on) |-> (core_in & InMask) == TieOff)
    else begin
      fail_cnt++;
      $error("Mismatch tie_off: expected %b actual %b", TieOff, core_in & InMask);
    end

  a_tdo: assert property (@(posedge clk_i)
      (run_cnt != 0 && jtag_on_q && attr_q[TdoIdx] == '0) |->
      (pad_oe[TdoIdx] && pad_out[TdoIdx] == tdo_q))
    else begin
      fail_cnt++;
      $error("Mismatch tdo_pad: expected 1%b actual %b%b", tdo_q, pad_oe[TdoIdx],
             pad_out[TdoIdx]);
    end

  a_jtag_pad_oe: assert property (@(posedge clk_i)
      (run_cnt != 0 && jtag_on_q) |-> (pad_oe & InMask) == '0)
    else begin
      fail_cnt++;
      $error("JTAG input pad drives out: %b", pad_oe & InMask);
    end

  a_idle: assert property (@(posedge clk_i) (run_cnt >= 2 && !jtag_on) |-> jtag_o == JtagOff)
    else begin
      fail_cnt++;
      $error("Mismatch jtag_idle: expected %b actual %b", JtagOff, jtag_o);
    end

endmodule : chip_io_assertions

bind chip_io_top chip_io_assertions #(
  .NumMio         ( NumMio         ),
  .NumDio         ( NumDio         ),
  .MioVariant     ( MioVariant     ),
  .DioVariant     ( DioVariant     ),
  .JtagEnPolarity ( JtagEnPolarity )
) u_asserts (
  .clk_i         ( clk_i         ),
  .rst_n_i       ( rst_n_i       ),
  .mio_drive_i   ( mio_drive_i   ),
  .dio_drive_i   ( dio_drive_i   ),
  .mio_attr_i    ( mio_attr_i    ),
  .dio_attr_i    ( dio_attr_i    ),
  .mio_in_o      ( mio_in_o      ),
  .dio_in_o      ( dio_in_o      ),
  .mio_pad_in_i  ( mio_pad_in_i  ),
  .dio_pad_in_i  ( dio_pad_in_i  ),
  .mio_pad_out_o ( mio_pad_out_o ),
  .mio_pad_oe_o  ( mio_pad_oe_o  ),
  .dio_pad_out_o ( dio_pad_out_o ),
  .dio_pad_oe_o  ( dio_pad_oe_o  ),
  .jtag_o        ( jtag_o        ),
  .jtag_tdo_i    ( jtag_tdo_i    )
);

`default_nettype wire

/* design/chip_io_top.sv */
// Chip pad layer: MIO and DIO pad banks with the JTAG overlay between core and banks
// JTAG pad positions come from the package defaults, TCK/TMS/TDI/TDO on DIO pads
`default_nettype none

module chip_io_top #(
  parameter int   NumMio         = chip_io_pkg::NumMioDefault,
  parameter int   NumDio         = chip_io_pkg::NumDioDefault,
  parameter chip_io_pkg::pad_variant_e [NumMio-1:0] MioVariant =
      '{default: chip_io_pkg::bidir},
  parameter chip_io_pkg::pad_variant_e [NumDio-1:0] DioVariant =
      '{default: chip_io_pkg::bidir},
  parameter logic JtagEnPolarity = 1'b1  // Strap level for JTAG mode
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  // Core side, MIO
  input  chip_io_pkg::pad_drive_t [NumMio-1:0]  mio_drive_i,
  input  chip_io_pkg::pad_attr_t  [NumMio-1:0]  mio_attr_i,
  output logic                    [NumMio-1:0]  mio_in_o,
  // Core side, DIO
  input  chip_io_pkg::pad_drive_t [NumDio-1:0]  dio_drive_i,
  input  chip_io_pkg::pad_attr_t  [NumDio-1:0]  dio_attr_i,
  output logic                    [NumDio-1:0]  dio_in_o,
  // Pad ring, MIO
  input  logic                    [NumMio-1:0]  mio_pad_in_i,
  output logic                    [NumMio-1:0]  mio_pad_out_o,
  output logic                    [NumMio-1:0]  mio_pad_oe_o,
  // Pad ring, DIO
  input  logic                    [NumDio-1:0]  dio_pad_in_i,
  output logic                    [NumDio-1:0]  dio_pad_out_o,
  output logic                    [NumDio-1:0]  dio_pad_oe_o,
  // TAP
  output chip_io_pkg::jtag_t                    jtag_o,
  input  logic                                  jtag_tdo_i
);

  localparam int NumIOs = NumMio + NumDio;  // DIO above MIO

  ////////////////////////////////////////////////////////////////////////////
  // Joined vectors
  ////////////////////////////////////////////////////////////////////////////

  chip_io_pkg::pad_drive_t [NumIOs-1:0] core_drive;      // Core side, joined
  chip_io_pkg::pad_drive_t [NumIOs-1:0] bank_drive;      // After overlay
  chip_io_pkg::pad_drive_t [NumMio-1:0] mio_bank_drive;
  chip_io_pkg::pad_drive_t [NumDio-1:0] dio_bank_drive;
  logic                    [NumIOs-1:0] sync_in;         // Synced pads, joined
  logic                    [NumIOs-1:0] core_in;         // After overlay
  logic                    [NumMio-1:0] mio_sync_in;
  logic                    [NumDio-1:0] dio_sync_in;

  assign core_drive                       = {dio_drive_i, mio_drive_i};
  assign {dio_bank_drive, mio_bank_drive} = bank_drive;
  assign sync_in                          = {dio_sync_in, mio_sync_in};
  assign {dio_in_o, mio_in_o}             = core_in;

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  jtag_overlay_mux #(
    .NumIOs         ( NumIOs                             ),
    .JtagEnIdx      ( chip_io_pkg::JtagEnIdxDefault      ),  // MIO strap
    .JtagEnPolarity ( JtagEnPolarity                     ),
    .TckIdx         ( NumMio + chip_io_pkg::DioSck       ),
    .TmsIdx         ( NumMio + chip_io_pkg::DioCsb       ),
    .TrstIdx        ( chip_io_pkg::TrstIdxDefault        ),  // MIO
    .SrstIdx        ( chip_io_pkg::SrstIdxDefault        ),  // MIO
    .TdiIdx         ( NumMio + chip_io_pkg::DioS0        ),
    .TdoIdx         ( NumMio + chip_io_pkg::DioS1        )
  ) u_jtag_mux (
    .core_drive_i ( core_drive ),
    .core_in_o    ( core_in    ),
    .pad_drive_o  ( bank_drive ),
    .pad_in_i     ( sync_in    ),
    .jtag_o       ( jtag_o     ),
    .jtag_tdo_i   ( jtag_tdo_i )
  );

  pad_bank #(
    .NumPads ( NumMio     ),
    .Variant ( MioVariant )
  ) u_mio_bank (
    .clk_i     ( clk_i          ),
    .rst_n_i   ( rst_n_i        ),
    .drive_i   ( mio_bank_drive ),
    .attr_i    ( mio_attr_i     ),
    .in_o      ( mio_sync_in    ),
    .pad_in_i  ( mio_pad_in_i   ),
    .pad_out_o ( mio_pad_out_o  ),
    .pad_oe_o  ( mio_pad_oe_o   )
  );

  pad_bank #(
    .NumPads ( NumDio     ),
    .Variant ( DioVariant )
  ) u_dio_bank (
    .clk_i     ( clk_i          ),
    .rst_n_i   ( rst_n_i        ),
    .drive_i   ( dio_bank_drive ),
    .attr_i    ( dio_attr_i     ),
    .in_o      ( dio_sync_in    ),
    .pad_in_i  ( dio_pad_in_i   ),
    .pad_out_o ( dio_pad_out_o  ),
    .pad_oe_o  ( dio_pad_oe_o   )
  );

endmodule : chip_io_top

`default_nettype wire

/* design/jtag_overlay_mux.sv */
// Strap-selected JTAG overlay on the joined MIO/DIO vectors, purely combinational
// The strap is taken from the synchronized pads, so it acts two cycles after the pad
// JTAG indices must be distinct and must not include JtagEnIdx
`default_nettype none

module jtag_overlay_mux #(
  parameter int   NumIOs         = 14,
  parameter int   JtagEnIdx      = 5,     // Strap pad
  parameter logic JtagEnPolarity = 1'b1,  // Strap level that enables JTAG
  parameter int   TckIdx         = 8,
  parameter int   TmsIdx         = 9,
  parameter int   TrstIdx        = 2,
  parameter int   SrstIdx        = 3,
  parameter int   TdiIdx         = 10,
  parameter int   TdoIdx         = 11
) (
  // Core side
  input  chip_io_pkg::pad_drive_t [NumIOs-1:0] core_drive_i,
  output logic                    [NumIOs-1:0] core_in_o,
  // Pad bank side
  output chip_io_pkg::pad_drive_t [NumIOs-1:0] pad_drive_o,
  input  logic                    [NumIOs-1:0] pad_in_i,     // From synchronizers
  // TAP side
  output chip_io_pkg::jtag_t                   jtag_o,
  input  logic                                 jtag_tdo_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Pad masks
  ////////////////////////////////////////////////////////////////////////////

  // Pads taken over as TAP inputs
  localparam logic [NumIOs-1:0] JtagInMask = (NumIOs'(1) << TckIdx)  |
                                             (NumIOs'(1) << TmsIdx)  |
                                             (NumIOs'(1) << TrstIdx) |
                                             (NumIOs'(1) << SrstIdx) |
                                             (NumIOs'(1) << TdiIdx);

  // Core view of those pads in JTAG mode, TMS pad is an active low CSB
  localparam logic [NumIOs-1:0] TieOffValues = NumIOs'(1) << TmsIdx;

  logic jtag_en;  // Overlay active

  assign jtag_en = (pad_in_i[JtagEnIdx] == JtagEnPolarity);

  ////////////////////////////////////////////////////////////////////////////
  // Steering
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    pad_drive_o = core_drive_i;           // Pass through by default
    core_in_o   = pad_in_i;               // Strap always lands here
    jtag_o      = chip_io_pkg::JtagIdle;  // TAP held in reset

    if (jtag_en) begin
      jtag_o.tck    = pad_in_i[TckIdx];
      jtag_o.tms    = pad_in_i[TmsIdx];
      jtag_o.trst_n = pad_in_i[TrstIdx];
      jtag_o.srst_n = pad_in_i[SrstIdx];
      jtag_o.tdi    = pad_in_i[TdiIdx];

      // Core sees fixed values on the TAP input pads
      core_in_o = (pad_in_i & ~JtagInMask) | TieOffValues;

      // TAP input pads are receivers only
      for (int i = 0; i < NumIOs; i++) begin
        if (JtagInMask[i]) begin
          pad_drive_o[i] = '0;
        end
      end

      pad_drive_o[TdoIdx].out = jtag_tdo_i;  // TDO owns its pad
      pad_drive_o[TdoIdx].oe  = 1'b1;
    end
  end

endmodule : jtag_overlay_mux

`default_nettype wire

/* design/pad_bank.sv */
// Bank of pads modelled as split in/out/oe vectors, no inout nets
// Outputs are registered, one cycle from drive_i to the pads
// Inputs pass a two-flop synchronizer, two cycles from pad_in_i to in_o
`default_nettype none

module pad_bank #(
  parameter int NumPads = 8,
  parameter chip_io_pkg::pad_variant_e [NumPads-1:0] Variant =
      '{default: chip_io_pkg::bidir}
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  // Core side
  input  chip_io_pkg::pad_drive_t [NumPads-1:0]  drive_i,   // Out/oe per pad
  input  chip_io_pkg::pad_attr_t  [NumPads-1:0]  attr_i,    // Invert/od per pad
  output logic                    [NumPads-1:0]  in_o,      // Synced, inverted
  // Pad side
  input  logic                    [NumPads-1:0]  pad_in_i,
  output logic                    [NumPads-1:0]  pad_out_o,
  output logic                    [NumPads-1:0]  pad_oe_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Output path
  ////////////////////////////////////////////////////////////////////////////

  logic [NumPads-1:0] out_val;  // Core out after inversion
  logic [NumPads-1:0] od_mode;  // Pad acts as open drain
  logic [NumPads-1:0] out_d;    // Next pad out
  logic [NumPads-1:0] oe_d;     // Next pad oe

  always_comb begin
    for (int i = 0; i < NumPads; i++) begin
      out_val[i] = drive_i[i].out ^ attr_i[i].invert;
      od_mode[i] = (Variant[i] == chip_io_pkg::open_drain) | attr_i[i].od_en;
      case (Variant[i])
        chip_io_pkg::bidir,
        chip_io_pkg::tolerant,
        chip_io_pkg::open_drain: begin
          if (od_mode[i]) begin
            out_d[i] = 1'b0;                         // Only ever pulls low
            oe_d[i]  = drive_i[i].oe & ~out_val[i];  // Release on a 1
          end else begin
            out_d[i] = out_val[i];
            oe_d[i]  = drive_i[i].oe;
          end
        end
        default: begin  // input_only
          out_d[i] = 1'b0;
          oe_d[i]  = 1'b0;  // Receiver only
        end
      endcase
    end
  end

  // Pad output flops, all released after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pad_out_o <= '0;
      pad_oe_o  <= '0;  // No pad drives out of reset
    end else begin
      pad_out_o <= out_d;
      pad_oe_o  <= oe_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Input path
  ////////////////////////////////////////////////////////////////////////////

  logic [NumPads-1:0] sync_q1;  // First stage, may go metastable
  logic [NumPads-1:0] sync_q2;  // Second stage, safe to use

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_in_i;
      sync_q2 <= sync_q1;
    end
  end

  // Inversion after the synchronizer, follows attr_i live
  always_comb begin
    for (int i = 0; i < NumPads; i++) begin
      in_o[i] = sync_q2[i] ^ attr_i[i].invert;
    end
  end

endmodule : pad_bank

`default_nettype wire

/* design/chip_io_pkg.sv */
// Pad types, default pad counts and default pad indices for the chip IO layer
// In joined vectors the DIO pads sit above the MIO pads, MIO 0 at bit 0
`default_nettype none

package chip_io_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Pad variants and per-pad structs
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    bidir      = 2'd0,  // Plain bidirectional pad
    input_only = 2'd1,  // Receiver only, never drives
    tolerant   = 2'd2,  // High-voltage tolerant, handled as bidir
    open_drain = 2'd3   // Drives low only
  } pad_variant_e;

  typedef struct packed {
    logic invert;  // Flip value in both directions
    logic od_en;   // Virtual open drain from core
  } pad_attr_t;

  typedef struct packed {
    logic out;  // Output value
    logic oe;   // Output enable
  } pad_drive_t;

  typedef struct packed {
    logic tck;
    logic tms;
    logic trst_n;  // Active low TAP reset
    logic srst_n;  // Active low system reset
    logic tdi;
  } jtag_t;

  // Value seen by the TAP while the overlay is off
  localparam jtag_t JtagIdle = '{
    tck:    1'b0,
    tms:    1'b0,
    trst_n: 1'b0,  // Hold TAP in reset
    srst_n: 1'b1,  // No system reset
    tdi:    1'b0
  };

  ////////////////////////////////////////////////////////////////////////////
  // Default sizes and indices
  ////////////////////////////////////////////////////////////////////////////

  localparam int NumMioDefault = 8;  // MIO pad count
  localparam int NumDioDefault = 6;  // DIO pad count

  localparam int JtagEnIdxDefault = 5;  // Strap pad, MIO 5
  localparam int TrstIdxDefault   = 2;  // MIO 2
  localparam int SrstIdxDefault   = 3;  // MIO 3

  // Offsets inside the DIO bank
  localparam int DioSck = 0;  // TCK in JTAG mode
  localparam int DioCsb = 1;  // TMS in JTAG mode, active low CSB
  localparam int DioS0  = 2;  // TDI in JTAG mode
  localparam int DioS1  = 3;  // TDO in JTAG mode

endpackage : chip_io_pkg

`default_nettype wire
